/* hw/night_sky_top.sv */
`timescale 1ns/10ps

module night_sky_top import sky_pkg::*;
(
	input  logic       frame_Clk,
	input  logic       Reset,
	input  pixel_req_t write_req,
	input  logic       frame_start,
	input  logic       is_night,
	output sky_pixel_t pixel_out
);

	pixel_req_t   req_q;	// stage 1
	logic         valid_d;	// valid at the window stage
	sprite_desc_t desc [NUM_SLOTS];
	window_hit_t  hits [NUM_SLOTS];

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			req_q <= '0;
			valid_d <= 1'b0;
		end
		else
		begin
			req_q <= write_req;
			valid_d <= req_q.valid;
		end
	end

	sky_scheduler i_scheduler (
		.frame_Clk   (frame_Clk),
		.Reset       (Reset),
		.frame_start (frame_start),
		.is_night    (is_night),
		.desc        (desc)
	);

	// one window per slot, stage 2
	genvar s;
	generate
		for (s = 0; s < NUM_SLOTS; s = s + 1)
		begin : g_window
			sprite_window i_window (
				.frame_Clk (frame_Clk),
				.Reset     (Reset),
				.req       (req_q),
				.is_night  (is_night),
				.desc      (desc[s]),
				.hit       (hits[s])
			);
		end
	endgenerate

	sprite_address_mux i_mux (
		.frame_Clk (frame_Clk),
		.Reset     (Reset),
		.hits      (hits),
		.desc      (desc),
		.valid_in  (valid_d),
		.pixel_out (pixel_out)	// stage 3
	);

endmodule

/* hw/sky_pkg.sv */
package sky_pkg;

	localparam int NUM_SLOTS = 3;	// slot 0 moon, slots 1 and 2 stars

	// rom base of each moon phase, indexed by moon_phase_t
	localparam logic [17:0] MOON_BASE [0:6] = '{
		18'd142615,	// full, 80x80
		18'd149015,
		18'd152215,
		18'd155415,
		18'd158615,	// first of the right halves
		18'd161815,
		18'd165015
	};

	localparam logic [17:0] STAR_BASE [0:2] = '{
		18'd224411,
		18'd224717,
		18'd225059
	};

	localparam logic [6:0] STAR_HEIGHT [0:2] = '{7'd17, 7'd19, 7'd18};
	localparam logic [6:0] STAR_WIDTH = 7'd18;

	// moon sprite sizes
	localparam logic [6:0] MOON_FULL_W = 7'd80;
	localparam logic [6:0] MOON_HALF_W = 7'd40;
	localparam logic [6:0] MOON_H      = 7'd80;

	// screen positions
	localparam logic [9:0] MOON_LEFT_X  = 10'd10;
	localparam logic [9:0] MOON_RIGHT_X = 10'd40;
	localparam logic [9:0] MOON_Y       = 10'd10;
	localparam logic [9:0] STAR1_X      = 10'd100;
	localparam logic [9:0] STAR1_Y      = 10'd20;
	localparam logic [9:0] STAR2_X      = 10'd200;
	localparam logic [9:0] STAR2_Y      = 10'd60;

	localparam int FRAME_PERIOD = 30;	// frames per full star cycle
	localparam logic [5:0] LFSR_SEED = 6'b010101;

	typedef enum logic [2:0] {
		MOON_FULL,
		LEFT1,
		LEFT2,
		LEFT3,
		RIGHT1,
		RIGHT2,
		RIGHT3
	} moon_phase_t;

	typedef struct packed {
		logic       valid;
		logic [9:0] x;
		logic [9:0] y;
	} pixel_req_t;

	typedef struct packed {
		logic [17:0] base;
		logic [9:0]  loc_x;
		logic [9:0]  loc_y;
		logic [6:0]  size_x;
		logic [6:0]  size_y;
	} sprite_desc_t;

	typedef struct packed {
		logic       hit;
		logic [6:0] dist_x;	// offset from sprite origin
		logic [6:0] dist_y;
	} window_hit_t;

	typedef struct packed {
		logic        valid;
		logic [1:0]  code;	// 0 none, 1 moon, 2 star 1, 3 star 2
		logic [17:0] address;
	} sky_pixel_t;

endpackage

/* hw/sky_scheduler.sv */
`timescale 1ns/10ps

module sky_scheduler import sky_pkg::*;
(
	input  logic         frame_Clk,
	input  logic         Reset,
	input  logic         frame_start,	// one-cycle pulse per frame
	input  logic         is_night,
	output sprite_desc_t desc [NUM_SLOTS]
);

	logic [4:0]  frame_count;	// runs 1 .. FRAME_PERIOD
	logic [1:0]  star_idx;
	logic [5:0]  lfsr;
	logic        night_q;	// is_night one cycle ago
	logic        night_rise;
	moon_phase_t phase;
	moon_phase_t next_phase;

	// map the random value onto a phase, full moon twice as likely
	function automatic moon_phase_t pick_phase(input logic [5:0] r);
		moon_phase_t p;
		if (r < 6'd16)
			p = MOON_FULL;
		else if (r < 6'd24)
			p = LEFT1;
		else if (r < 6'd32)
			p = LEFT2;
		else if (r < 6'd40)
			p = LEFT3;
		else if (r < 6'd48)
			p = RIGHT1;
		else if (r < 6'd56)
			p = RIGHT2;
		else
			p = RIGHT3;
		return p;
	endfunction

	// star sprite changes every third of the period
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			frame_count <= 5'd1;
			star_idx <= 2'd0;
		end
		else if (frame_start)
		begin
			if (frame_count == 5'(FRAME_PERIOD))
			begin
				star_idx <= 2'd0;
				frame_count <= 5'd1;	// wrap back to the start
			end
			else
			begin
				if (frame_count == 5'd1)
					star_idx <= 2'd0;
				else if (frame_count == 5'(FRAME_PERIOD / 3))
					star_idx <= 2'd1;
				else if (frame_count == 5'(2 * FRAME_PERIOD / 3))
					star_idx <= 2'd2;
				frame_count <= frame_count + 5'd1;
			end
		end
	end

	assign night_rise = is_night & ~night_q;
	assign next_phase = pick_phase(lfsr);

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			lfsr <= LFSR_SEED;
			night_q <= 1'b0;
			phase <= MOON_FULL;
		end
		else
		begin
			night_q <= is_night;
			if (frame_start)
				lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};	// one step per frame
			if (night_rise)
				phase <= next_phase;	// value before this cycle's step
		end
	end

	always_comb
	begin
		// moon
		desc[0].base = MOON_BASE[phase];
		desc[0].loc_y = MOON_Y;
		desc[0].size_y = MOON_H;
		case (phase)
			MOON_FULL:
			begin
				desc[0].loc_x = MOON_LEFT_X;
				desc[0].size_x = MOON_FULL_W;
			end
			LEFT1, LEFT2, LEFT3:
			begin
				desc[0].loc_x = MOON_LEFT_X;
				desc[0].size_x = MOON_HALF_W;
			end
			default:	// right halves
			begin
				desc[0].loc_x = MOON_RIGHT_X;
				desc[0].size_x = MOON_HALF_W;
			end
		endcase

		// both stars share one sprite
		desc[1].base = STAR_BASE[star_idx];
		desc[1].loc_x = STAR1_X;
		desc[1].loc_y = STAR1_Y;
		desc[1].size_x = STAR_WIDTH;
		desc[1].size_y = STAR_HEIGHT[star_idx];

		desc[2].base = STAR_BASE[star_idx];
		desc[2].loc_x = STAR2_X;
		desc[2].loc_y = STAR2_Y;
		desc[2].size_x = STAR_WIDTH;
		desc[2].size_y = STAR_HEIGHT[star_idx];
	end

endmodule

/* hw/sprite_address_mux.sv */
`timescale 1ns/10ps

module sprite_address_mux import sky_pkg::*;
(
	input  logic         frame_Clk,
	input  logic         Reset,
	input  window_hit_t  hits [NUM_SLOTS],
	input  sprite_desc_t desc [NUM_SLOTS],
	input  logic         valid_in,	// aligned with hits
	output sky_pixel_t   pixel_out
);

	logic [1:0]  code;
	logic [17:0] base;
	logic [6:0]  size_x;
	logic [6:0]  dist_x;
	logic [6:0]  dist_y;
	logic [17:0] address;

	// fixed priority, the moon in front of both stars
	always_comb
	begin
		code = 2'd0;
		base = '0;
		size_x = '0;
		dist_x = '0;
		dist_y = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--)	// lowest slot written last
		begin
			if (hits[i].hit)
			begin
				code = 2'(i + 1);
				base = desc[i].base;
				size_x = desc[i].size_x;
				dist_x = hits[i].dist_x;
				dist_y = hits[i].dist_y;
			end
		end
	end

	// row-major offset into the sprite
	assign address = base + (18'(dist_y) * 18'(size_x)) + 18'(dist_x);

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			pixel_out <= '0;
		else
		begin
			pixel_out.valid <= valid_in;
			pixel_out.code <= code;
			pixel_out.address <= address;	// zero when nothing hits
		end
	end

endmodule

/* hw/sprite_window.sv */
`timescale 1ns/10ps

module sprite_window import sky_pkg::*;
(
	input  logic         frame_Clk,
	input  logic         Reset,
	input  pixel_req_t   req,
	input  logic         is_night,
	input  sprite_desc_t desc,
	output window_hit_t  hit
);

	logic [10:0] end_x;	// one past the right edge
	logic [10:0] end_y;	// one past the bottom edge
	logic        in_x;
	logic        in_y;
	logic [6:0]  dist_x;
	logic [6:0]  dist_y;

	// extra bit so the edge sum cannot wrap
	assign end_x = {1'b0, desc.loc_x} + 11'(desc.size_x);
	assign end_y = {1'b0, desc.loc_y} + 11'(desc.size_y);

	assign in_x = (req.x >= desc.loc_x) && ({1'b0, req.x} < end_x);
	assign in_y = (req.y >= desc.loc_y) && ({1'b0, req.y} < end_y);

	assign dist_x = 7'(req.x - desc.loc_x);	// only meaningful inside
	assign dist_y = 7'(req.y - desc.loc_y);

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			hit <= '0;
		else
		begin
			hit.hit <= req.valid && is_night && in_x && in_y;
			hit.dist_x <= dist_x;
			hit.dist_y <= dist_y;
		end
	end

endmodule

/* night_sky.f */
hw/sky_pkg.sv
hw/sky_scheduler.sv
hw/sprite_window.sv
hw/sprite_address_mux.sv
hw/night_sky_top.sv
sim/tb_night_sky.sv

/* run_sim.sh */
#!/bin/sh
# build the night_sky testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_night_sky -f night_sky.f || exit 1
out=$(./obj_dir/Vtb_night_sky)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim/night_sky_testdata.txt */
# columns: action x y is_night expected_code expected_address, all decimal
# a test line opens a named test and its x column holds the test number
test 1 0 0 0 0
pixel 10 10 0 0 0
pixel 50 50 0 0 0
pixel 100 20 0 0 0
pixel 200 60 0 0 0
test 2 0 1 0 0
night 0 0 1 0 0
pixel 10 10 1 1 149015
pixel 49 89 1 1 152214
pixel 50 10 1 0 0
pixel 100 20 1 2 224411
pixel 117 36 1 2 224716
pixel 100 37 1 0 0
pixel 200 60 1 3 224411
pixel 217 76 1 3 224716
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
pixel 117 36 1 2 224716
pixel 200 60 1 3 224411
test 3 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
night 0 0 0 0 0
night 0 0 1 0 0
pixel 10 10 1 1 142615
pixel 89 10 1 1 142694
pixel 10 89 1 1 148935
pixel 89 89 1 1 149014
pixel 50 50 1 1 145855
pixel 9 10 1 0 0
pixel 90 50 1 0 0
pixel 50 9 1 0 0
pixel 50 90 1 0 0
test 4 0 1 0 0
pixel 100 20 1 2 224717
pixel 100 38 1 2 225041
pixel 117 38 1 2 225058
pixel 100 39 1 0 0
pixel 200 60 1 3 224717
pixel 217 78 1 3 225058
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
frame 0 0 1 0 0
pixel 100 20 1 2 225059
pixel 117 37 1 2 225382
pixel 100 38 1 0 0
pixel 200 60 1 3 225059
pixel 217 77 1 3 225382
pixel 217 78 1 0 0
test 5 0 1 0 0
frame 0 0 1 0 0
night 0 0 0 0 0
night 0 0 1 0 0
pixel 40 10 1 1 161815
pixel 79 89 1 1 165014
pixel 60 50 1 1 163435
pixel 10 10 1 0 0
pixel 39 50 1 0 0
pixel 80 50 1 0 0
test 6 0 1 0 0
pixel 40 10 1 1 161815
pixel 100 20 1 2 225059
pixel 0 0 1 0 0
pixel 200 60 1 3 225059
pixel 41 11 1 1 161856
pixel 217 77 1 3 225382

/* sim/tb_night_sky.sv */
`timescale 1ns/10ps

module tb_night_sky import sky_pkg::*;
();

	typedef struct packed {
		logic [9:0]  x;	// test number on a test line
		logic [9:0]  y;
		logic        night;
		logic [1:0]  code;
		logic [17:0] address;
	} step_t;

	typedef struct packed {
		logic [31:0] issue;	// cycle the pixel went in
		logic [9:0]  x;
		logic [9:0]  y;
		logic [1:0]  code;
		logic [17:0] address;
	} expect_t;

	logic       frame_Clk;
	logic       Reset;
	pixel_req_t write_req;
	logic       frame_start;
	logic       is_night;
	sky_pixel_t pixel_out;

	string   act_q [$];
	step_t   step_q [$];
	expect_t exp_q [$];	// pixels still in the pipeline
	bit      loaded;
	int      cycle;
	int      test_id;
	int      test_pixels;
	int      test_errors;
	int      num_tests;
	int      num_checks;
	int      num_errors;

	night_sky_top i_night_sky_top (
		.frame_Clk   (frame_Clk),
		.Reset       (Reset),
		.write_req   (write_req),
		.frame_start (frame_start),
		.is_night    (is_night),
		.pixel_out   (pixel_out)
	);

	always #50 frame_Clk = ~frame_Clk;

	function automatic string test_name(input int n);
		case (n)
			1: return "idle_after_reset";
			2: return "first_night_stars";
			3: return "full_moon_window";
			4: return "star_cycle";
			5: return "moon_phase_change";
			6: return "back_to_back";
			default: return "unnamed";
		endcase
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic note_failure(input string what);
		$display("%s: %s", test_name(test_id), what);
		num_errors++;
		test_errors++;
	endtask

	task automatic report_mismatch(input string what, input expect_t e, input int expected,
		input int actual);
		$display("** Error: %s %s at (%0d,%0d) expected %0d actual %0d", test_name(test_id),
			what, e.x, e.y, expected, actual);
		num_errors++;
		test_errors++;
	endtask

	task automatic load_steps(output bit ok);
		int    fd;
		int    n;
		int    x;
		int    y;
		int    nt;
		int    c;
		int    a;
		string line;
		string act;
		step_t s;
		fd = $fopen("sim/night_sky_testdata.txt", "r");
		ok = (fd != 0);
		if (ok)
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#")	// skip comments and blank lines
				begin
					n = $sscanf(line, "%s %d %d %d %d %d", act, x, y, nt, c, a);
					if (n == 6)
					begin
						s.x = 10'(x);
						s.y = 10'(y);
						s.night = nt[0];
						s.code = 2'(c);
						s.address = 18'(a);
						act_q.push_back(act);
						step_q.push_back(s);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_output();
		expect_t e;
		if (pixel_out.valid)
		begin
			assert (exp_q.size() > 0)
			else
				note_failure("output valid while no pixel request was pending");
			if (exp_q.size() > 0)
			begin
				e = exp_q.pop_front();
				num_checks++;
				test_pixels++;
				assert (cycle == int'(e.issue) + 3)
				else
					report_mismatch("latency", e, 3, cycle - int'(e.issue));
				assert (pixel_out.code == e.code)
				else
					report_mismatch("code", e, int'(e.code), int'(pixel_out.code));
				assert (pixel_out.address == e.address)
				else
					report_mismatch("address", e, int'(e.address), int'(pixel_out.address));
			end
		end
		else if (exp_q.size() > 0)
		begin
			assert (cycle <= int'(exp_q[0].issue) + 3)
			else
			begin
				e = exp_q.pop_front();
				note_failure($sformatf("no output came for pixel (%0d,%0d)", e.x, e.y));
			end
		end
	endtask

	// outputs are sampled on the falling edge, before new inputs go out
	task automatic next_cycle();
		@(negedge frame_Clk);
		cycle++;
		check_output();
	endtask

	task automatic idle_inputs();
		write_req = '0;
		frame_start = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() > 0)
		begin
			next_cycle();
			idle_inputs();
		end
	endtask

	task automatic close_test();
		if (test_id != 0)
		begin
			drain();
			$display("test %0d %s finished: %0d pixels, %0d errors", test_id,
				test_name(test_id), test_pixels, test_errors);
		end
	endtask

	task automatic run_step(input string act, input step_t s);
		expect_t e;
		if (act == "test")
		begin
			close_test();
			test_id = int'(s.x);
			test_pixels = 0;
			test_errors = 0;
			num_tests++;
		end
		else
		begin
			if (act != "pixel")
				drain();	// descriptors must not change under a pixel in flight
			next_cycle();
			idle_inputs();
			is_night = s.night;
			if (act == "pixel")
			begin
				write_req.valid = 1'b1;
				write_req.x = s.x;
				write_req.y = s.y;
				e.issue = 32'(cycle);
				e.x = s.x;
				e.y = s.y;
				e.code = s.code;
				e.address = s.address;
				exp_q.push_back(e);
			end
			else if (act == "frame")
			begin
				frame_start = 1'b1;
				next_cycle();	// strobe lasts one cycle
				idle_inputs();
			end
			else if (act != "night")
				note_failure($sformatf("unknown action %s in test data", act));
		end
	endtask

	// watchdog sized from the number of steps
	initial
	begin
		wait (loaded);
		#(act_q.size() * 200 + 20000);
		abort_run("watchdog timeout, the run did not finish in time");
	end

	initial
	begin
		bit ok;
		frame_Clk = 1'b0;
		Reset = 1'b1;
		write_req = '0;
		frame_start = 1'b0;
		is_night = 1'b0;
		cycle = 0;
		test_id = 0;
		test_pixels = 0;
		test_errors = 0;
		num_tests = 0;
		num_checks = 0;
		num_errors = 0;
		loaded = 1'b0;
		load_steps(ok);
		if (!ok || act_q.size() == 0)
			abort_run("cannot read any steps from sim/night_sky_testdata.txt");
		else
		begin
			loaded = 1'b1;
			repeat (4) @(negedge frame_Clk);
			Reset = 1'b0;
			for (int i = 0; i < act_q.size(); i++)
				run_step(act_q[i], step_q[i]);
			close_test();
			repeat (4)	// catch stray outputs
			begin
				next_cycle();
				idle_inputs();
			end
			$display("tests %0d, pixel checks %0d, errors %0d", num_tests, num_checks,
				num_errors);
			if (num_errors == 0)
				$display("RESULT: PASS");
			else
				$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule
